/* Bender.yml */
package:
  name: gat_feature_stage

sources:
  - include_dirs:
      - .
    files:
      - gat_pkg.sv
      - gat_weight_store.sv
      - gat_spmm_row.sv
      - gat_attn_score.sv
      - gat_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - gat_tb_chk.sv
      - gat_tb.sv

/* gat_attn_score.sv */
// ==========================================================================
// GAT attention score pipeline
// Two stages forming LeakyReLU(a . WH), with the WH row carried along
// ==========================================================================

`include "gat_settings.svh"

module gat_attn_score (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               row_vld_i,
  output logic                               row_rdy_o,
  input  gat_pkg::wh_t [`GAT_FEAT_OUT-1:0]   row_wh_i,
  input  gat_pkg::data_t [`GAT_FEAT_OUT-1:0] a_vec_i,
  output logic                               out_vld_o,
  input  logic                               out_rdy_i,
  output gat_pkg::wh_t [`GAT_FEAT_OUT-1:0]   out_wh_o,
  output gat_pkg::score_t                    out_score_o
);
  import gat_pkg::*;

  logic                    adv;
  logic                    s1_vld_q;
  score_t                  s1_prod_q [`GAT_FEAT_OUT];
  wh_t [`GAT_FEAT_OUT-1:0] s1_wh_q;
  score_t                  dot_sum;
  score_t                  lrelu;

  // Whole pipe moves when the output slot is free or being taken
  assign adv       = !out_vld_o || out_rdy_i;
  assign row_rdy_o = adv;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_vld_q  <= 1'b0;
      out_vld_o <= 1'b0;
    end else if (adv) begin
      s1_vld_q  <= row_vld_i;
      out_vld_o <= s1_vld_q;
    end
  end

  // ========================================================================
  // Stage one, element products
  // ========================================================================
  always_ff @(posedge clk) begin
    if (adv && row_vld_i) begin
      for (int k = 0; k < `GAT_FEAT_OUT; k++) begin
        s1_prod_q[k] <= $signed(a_vec_i[k]) * $signed(row_wh_i[k]);
      end
      s1_wh_q <= row_wh_i;
    end
  end

  // ========================================================================
  // Stage two, sum and LeakyReLU
  // ========================================================================
  always_comb begin
    dot_sum = '0;
    for (int k = 0; k < `GAT_FEAT_OUT; k++) begin
      dot_sum = dot_sum + s1_prod_q[k];
    end
    // Negative slope of 2^-shift
    lrelu = (dot_sum < 0) ? (dot_sum >>> `GAT_LRELU_SHIFT) : dot_sum;
  end

  always_ff @(posedge clk) begin
    if (adv && s1_vld_q) begin
      out_wh_o    <= s1_wh_q;
      out_score_o <= lrelu;
    end
  end

endmodule

/* gat_pkg.sv */
// ==========================================================================
// GAT feature stage types
// Width typedefs and the row accumulator state encoding
// ==========================================================================

`include "gat_settings.svh"

package gat_pkg;

  // Feature, weight and attention values
  typedef logic signed [`GAT_DATA_W-1:0] data_t;

  // Sparse column index, also the W row select
  typedef logic [$clog2(`GAT_FEAT_IN)-1:0] col_idx_t;

  // W address is row * GAT_FEAT_OUT + column
  typedef logic [$clog2(`GAT_FEAT_IN*`GAT_FEAT_OUT)-1:0] wgt_addr_t;
  typedef logic [$clog2(`GAT_FEAT_OUT)-1:0] att_addr_t;

  typedef logic signed [`GAT_WH_W-1:0]    wh_t;
  typedef logic signed [`GAT_SCORE_W-1:0] score_t;

  typedef enum logic [1:0] {
    ACC_IDLE,
    ACC_RUN,
    ACC_HOLD
  } acc_state_t;

endpackage

/* gat_settings.svh */
// ==========================================================================
// GAT feature stage sizing
// Feature counts and datapath widths shared by package and RTL
// ==========================================================================

`ifndef GAT_SETTINGS_SVH
`define GAT_SETTINGS_SVH

// Feature counts
`define GAT_FEAT_IN      8
`define GAT_FEAT_OUT     4

// Datapath widths
`define GAT_DATA_W       8
`define GAT_WH_W         20
`define GAT_SCORE_W      32
`define GAT_LRELU_SHIFT  3

`endif

/* gat_spmm_row.sv */
// ==========================================================================
// GAT sparse row accumulator
// Multiplies each node's sparse feature row by W, one entry per cycle,
// and hands the finished WH row to the score pipeline
// ==========================================================================

`include "gat_settings.svh"

module gat_spmm_row (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               load_done_i,
  input  logic                               in_vld_i,
  output logic                               in_rdy_o,
  input  gat_pkg::data_t                     in_val_i,
  input  gat_pkg::col_idx_t                  in_col_i,
  input  logic                               in_last_i,
  output gat_pkg::col_idx_t                  rd_row_o,
  input  gat_pkg::data_t [`GAT_FEAT_OUT-1:0] w_row_i,
  output logic                               row_vld_o,
  input  logic                               row_rdy_i,
  output gat_pkg::wh_t [`GAT_FEAT_OUT-1:0]   row_wh_o
);
  import gat_pkg::*;

  acc_state_t state_q;
  acc_state_t state_d;
  logic       first_q;
  logic       accept;
  wh_t        prod [`GAT_FEAT_OUT];

  // Open while running, or when the held row leaves this cycle
  assign in_rdy_o = load_done_i &&
                    ((state_q == ACC_RUN) || ((state_q == ACC_HOLD) && row_rdy_i));
  assign accept    = in_vld_i && in_rdy_o;
  assign rd_row_o  = in_col_i;
  assign row_vld_o = (state_q == ACC_HOLD);

  // Entry value times the selected W row
  always_comb begin
    for (int k = 0; k < `GAT_FEAT_OUT; k++) begin
      prod[k] = in_val_i * $signed(w_row_i[k]);
    end
  end

  // ========================================================================
  // Row FSM
  // ========================================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      ACC_IDLE: begin
        if (load_done_i) begin
          state_d = ACC_RUN;
        end
      end
      ACC_RUN: begin
        if (accept && in_last_i) begin
          state_d = ACC_HOLD;
        end
      end
      ACC_HOLD: begin
        // A single-entry row can finish while the previous one leaves
        if (row_rdy_i && !(accept && in_last_i)) begin
          state_d = ACC_RUN;
        end
      end
      default: begin
        state_d = ACC_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ACC_IDLE;
      first_q <= 1'b1;
    end else begin
      state_q <= state_d;
      if (accept) begin
        first_q <= in_last_i;
      end
    end
  end

  // ========================================================================
  // Accumulators, also the row output register
  // ========================================================================
  always_ff @(posedge clk) begin
    if (accept) begin
      for (int k = 0; k < `GAT_FEAT_OUT; k++) begin
        row_wh_o[k] <= first_q ? prod[k] : row_wh_o[k] + prod[k];
      end
    end
  end

endmodule

/* gat_tb.sv */
// ==========================================================================
// GAT feature stage testbench
// Table of sparse node rows applied in a loop, checked against a model
// of W, a and LeakyReLU, with random back-pressure on the result port
// ==========================================================================

`include "gat_settings.svh"

module gat_tb;
  import gat_pkg::*;

  localparam int N_NODES     = 6;
  localparam int N_ENT       = 20;
  localparam int N_RUNS      = 3;
  localparam int N_WGT       = `GAT_FEAT_IN * `GAT_FEAT_OUT;
  localparam int TIMEOUT_CYC = 20 * N_ENT * N_RUNS + 200;

  // Node n owns the sparse entries up to node_last[n]
  int ent_val [N_ENT] = '{5, -3, 7, -9, 1, -2, 3, -4, 5, -6,
                          7, -8, 12, -20, 6, 127, -128, -50, 33, 100};
  int ent_col [N_ENT] = '{0, 2, 5, 3, 0, 1, 2, 3, 4, 5,
                          6, 7, 1, 1, 4, 7, 6, 0, 3, 6};
  int node_last [N_NODES] = '{2, 3, 11, 14, 15, 19};

  logic                    clk;
  logic                    rst_n;
  logic                    wgt_we;
  wgt_addr_t               wgt_addr;
  data_t                   wgt_din;
  logic                    att_we;
  att_addr_t               att_addr;
  data_t                   att_din;
  logic                    load_done;
  logic                    in_vld;
  logic                    in_rdy;
  data_t                   in_val;
  col_idx_t                in_col;
  logic                    in_last;
  logic                    out_vld;
  logic                    out_rdy;
  wh_t [`GAT_FEAT_OUT-1:0] out_wh;
  score_t                  out_score;

  // Model copies of W and a
  int          w_m [`GAT_FEAT_IN][`GAT_FEAT_OUT];
  int          a_m [`GAT_FEAT_OUT];
  logic [31:0] rng_q;
  int          cyc;
  bit          bp_en;
  bit          lat_chk;
  int          exp_wh_q [$];
  int          exp_sc_q [$];
  int          acc_cyc_q [$];

  gat_top dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .wgt_we_i    (wgt_we),
    .wgt_addr_i  (wgt_addr),
    .wgt_din_i   (wgt_din),
    .att_we_i    (att_we),
    .att_addr_i  (att_addr),
    .att_din_i   (att_din),
    .load_done_i (load_done),
    .in_vld_i    (in_vld),
    .in_rdy_o    (in_rdy),
    .in_val_i    (in_val),
    .in_col_i    (in_col),
    .in_last_i   (in_last),
    .out_vld_o   (out_vld),
    .out_rdy_i   (out_rdy),
    .out_wh_o    (out_wh),
    .out_score_o (out_score)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand_next();
    rng_q = xorshift32(rng_q);
    return rng_q;
  endfunction

  task automatic check_val(input string name, input logic signed [63:0] got,
                           input logic signed [63:0] exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  // ========================================================================
  // Cycle counter and timeout
  // ========================================================================
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYC) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("FAIL: see errors above");
      $fatal(1);
    end else if (dut.u_chk.fail_cnt != 0) begin
      $display("Handshake assertion failed before %0t", $time);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  end

  // Sink ready is random while back-pressure is on
  always @(posedge clk) begin
    logic [31:0] r;
    if (bp_en) begin
      r = rand_next();
      out_rdy <= (r[1:0] != 2'b00);
    end else begin
      out_rdy <= 1'b1;
    end
  end

  // ========================================================================
  // Result monitor
  // ========================================================================
  always @(posedge clk) begin
    if (rst_n && out_vld && out_rdy) begin
      if (exp_sc_q.size() == 0) begin
        $display("Result seen at %0t with no node outstanding", $time);
        $display("FAIL: see errors above");
        $fatal(1);
      end else begin
        for (int k = 0; k < `GAT_FEAT_OUT; k++) begin
          check_val($sformatf("out_wh_o[%0d]", k), $signed(out_wh[k]), exp_wh_q.pop_front());
        end
        check_val("out_score_o", out_score, exp_sc_q.pop_front());
        if (lat_chk) begin
          check_val("out_vld_o latency", cyc - acc_cyc_q[0], 3);
        end
        void'(acc_cyc_q.pop_front());
      end
    end
  end

  // WH row and LeakyReLU score of node n from the model W and a
  task automatic push_expected(input int n);
    int first;
    int wh;
    int sum;
    first = (n == 0) ? 0 : node_last[n-1] + 1;
    sum   = 0;
    for (int k = 0; k < `GAT_FEAT_OUT; k++) begin
      wh = 0;
      for (int e = first; e <= node_last[n]; e++) begin
        wh += ent_val[e] * w_m[ent_col[e]][k];
      end
      exp_wh_q.push_back(wh);
      sum += a_m[k] * wh;
    end
    exp_sc_q.push_back((sum < 0) ? (sum >>> `GAT_LRELU_SHIFT) : sum);
  endtask

  task automatic load_params(input bit chk_rdy);
    logic [31:0] r;
    for (int i = 0; i < N_WGT; i++) begin
      @(posedge clk);
      if (chk_rdy) begin
        check_val("in_rdy_o", in_rdy, 0);
      end
      r = rand_next();
      w_m[i / `GAT_FEAT_OUT][i % `GAT_FEAT_OUT] = $signed(r[7:0]);
      wgt_we   <= 1'b1;
      wgt_addr <= wgt_addr_t'(i);
      wgt_din  <= r[7:0];
    end
    for (int k = 0; k < `GAT_FEAT_OUT; k++) begin
      @(posedge clk);
      if (chk_rdy) begin
        check_val("in_rdy_o", in_rdy, 0);
      end
      r = rand_next();
      a_m[k] = $signed(r[7:0]);
      wgt_we   <= 1'b0;
      att_we   <= 1'b1;
      att_addr <= att_addr_t'(k);
      att_din  <= r[7:0];
    end
    @(posedge clk);
    att_we <= 1'b0;
  endtask

  // Stream every node of the table, then wait for the pipe to drain
  task automatic run_table();
    int first;
    first = 0;
    for (int n = 0; n < N_NODES; n++) begin
      push_expected(n);
      for (int e = first; e <= node_last[n]; e++) begin
        in_vld  <= 1'b1;
        in_val  <= data_t'(ent_val[e]);
        in_col  <= col_idx_t'(ent_col[e]);
        in_last <= (e == node_last[n]);
        do @(posedge clk); while (!in_rdy);
      end
      acc_cyc_q.push_back(cyc);
      first = node_last[n] + 1;
    end
    in_vld  <= 1'b0;
    in_last <= 1'b0;
    while (exp_sc_q.size() != 0) @(posedge clk);
  endtask

  // ========================================================================
  // Main sequence
  // ========================================================================
  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    wgt_we    = 1'b0;
    wgt_addr  = '0;
    wgt_din   = '0;
    att_we    = 1'b0;
    att_addr  = '0;
    att_din   = '0;
    load_done = 1'b0;
    in_vld    = 1'b0;
    in_val    = '0;
    in_col    = '0;
    in_last   = 1'b0;
    out_rdy   = 1'b1;
    rng_q     = 32'd35419;
    cyc       = 0;
    bp_en     = 1'b0;
    lat_chk   = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    // Stream offered during the parameter load must be held off
    in_vld  <= 1'b1;
    in_val  <= 8'sd1;
    in_last <= 1'b1;
    load_params(1'b1);
    in_vld  <= 1'b0;
    in_last <= 1'b0;
    @(posedge clk);
    check_val("in_rdy_o", in_rdy, 0);
    load_done <= 1'b1;

    // Free-running sink gives a fixed latency
    lat_chk <= 1'b1;
    run_table();
    lat_chk <= 1'b0;
    bp_en   <= 1'b1;
    run_table();

    // Same rows again with new W and a
    bp_en <= 1'b0;
    load_params(1'b0);
    bp_en <= 1'b1;
    run_table();
    bp_en <= 1'b0;
    repeat (4) @(posedge clk);

    if (dut.u_chk.fail_cnt == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("Handshake assertions failed %0d times", dut.u_chk.fail_cnt);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  end

endmodule

/* gat_tb_chk.sv */
// ==========================================================================
// GAT feature stage handshake checker
// Stall stability, load gating and reset rules on the top level ports
// ==========================================================================

`include "gat_settings.svh"

module gat_tb_chk (
  input logic                             clk,
  input logic                             rst_n,
  input logic                             load_done_i,
  input logic                             in_rdy_o,
  input logic                             out_vld_o,
  input logic                             out_rdy_i,
  input gat_pkg::wh_t [`GAT_FEAT_OUT-1:0] out_wh_o,
  input gat_pkg::score_t                  out_score_o
);

  int unsigned fail_cnt = 0;

  // Held result must not move while the sink stalls
  hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
      out_vld_o && !out_rdy_i |=> out_vld_o && $stable(out_wh_o) && $stable(out_score_o))
    else begin
      $error("result changed or dropped while stalled");
      fail_cnt++;
    end

  no_rdy_before_load: assert property (@(posedge clk) disable iff (!rst_n)
      !load_done_i |-> !in_rdy_o)
    else begin
      $error("in_rdy_o high before load done");
      fail_cnt++;
    end

  // First cycle out of reset
  quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !out_vld_o && !in_rdy_o)
    else begin
      $error("handshake active right after reset");
      fail_cnt++;
    end

endmodule

bind gat_top gat_tb_chk u_chk (
  .clk         (clk),
  .rst_n       (rst_n),
  .load_done_i (load_done_i),
  .in_rdy_o    (in_rdy_o),
  .out_vld_o   (out_vld_o),
  .out_rdy_i   (out_rdy_i),
  .out_wh_o    (out_wh_o),
  .out_score_o (out_score_o)
);

/* gat_top.sv */
// ==========================================================================
// GAT first-layer feature stage
// Weight store, sparse row accumulator and attention score pipeline
// ==========================================================================

`include "gat_settings.svh"

module gat_top (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               wgt_we_i,
  input  gat_pkg::wgt_addr_t                 wgt_addr_i,
  input  gat_pkg::data_t                     wgt_din_i,
  input  logic                               att_we_i,
  input  gat_pkg::att_addr_t                 att_addr_i,
  input  gat_pkg::data_t                     att_din_i,
  input  logic                               load_done_i,
  input  logic                               in_vld_i,
  output logic                               in_rdy_o,
  input  gat_pkg::data_t                     in_val_i,
  input  gat_pkg::col_idx_t                  in_col_i,
  input  logic                               in_last_i,
  output logic                               out_vld_o,
  input  logic                               out_rdy_i,
  output gat_pkg::wh_t [`GAT_FEAT_OUT-1:0]   out_wh_o,
  output gat_pkg::score_t                    out_score_o
);
  import gat_pkg::*;

  col_idx_t                  rd_row;
  data_t [`GAT_FEAT_OUT-1:0] w_row;
  data_t [`GAT_FEAT_OUT-1:0] a_vec;
  logic                      row_vld;
  logic                      row_rdy;
  wh_t [`GAT_FEAT_OUT-1:0]   row_wh;

  gat_weight_store u_weight_store (
    .clk        (clk),
    .rst_n      (rst_n),
    .wgt_we_i   (wgt_we_i),
    .wgt_addr_i (wgt_addr_i),
    .wgt_din_i  (wgt_din_i),
    .att_we_i   (att_we_i),
    .att_addr_i (att_addr_i),
    .att_din_i  (att_din_i),
    .rd_row_i   (rd_row),
    .w_row_o    (w_row),
    .a_vec_o    (a_vec)
  );

  gat_spmm_row u_spmm_row (
    .clk         (clk),
    .rst_n       (rst_n),
    .load_done_i (load_done_i),
    .in_vld_i    (in_vld_i),
    .in_rdy_o    (in_rdy_o),
    .in_val_i    (in_val_i),
    .in_col_i    (in_col_i),
    .in_last_i   (in_last_i),
    .rd_row_o    (rd_row),
    .w_row_i     (w_row),
    .row_vld_o   (row_vld),
    .row_rdy_i   (row_rdy),
    .row_wh_o    (row_wh)
  );

  gat_attn_score u_attn_score (
    .clk         (clk),
    .rst_n       (rst_n),
    .row_vld_i   (row_vld),
    .row_rdy_o   (row_rdy),
    .row_wh_i    (row_wh),
    .a_vec_i     (a_vec),
    .out_vld_o   (out_vld_o),
    .out_rdy_i   (out_rdy_i),
    .out_wh_o    (out_wh_o),
    .out_score_o (out_score_o)
  );

endmodule

/* gat_weight_store.sv */
// ==========================================================================
// GAT weight store
// Holds W and the source half of a, written by the host, and presents
// one W row plus the full a vector to the compute stage
// ==========================================================================

`include "gat_settings.svh"

module gat_weight_store (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               wgt_we_i,
  input  gat_pkg::wgt_addr_t                 wgt_addr_i,
  input  gat_pkg::data_t                     wgt_din_i,
  input  logic                               att_we_i,
  input  gat_pkg::att_addr_t                 att_addr_i,
  input  gat_pkg::data_t                     att_din_i,
  input  gat_pkg::col_idx_t                  rd_row_i,
  output gat_pkg::data_t [`GAT_FEAT_OUT-1:0] w_row_o,
  output gat_pkg::data_t [`GAT_FEAT_OUT-1:0] a_vec_o
);
  import gat_pkg::*;

  // Column part of a W address, row part above it
  localparam int COL_W  = $bits(att_addr_t);
  localparam int ADDR_W = $bits(wgt_addr_t);

  data_t [`GAT_FEAT_OUT-1:0] w_q [`GAT_FEAT_IN];
  data_t [`GAT_FEAT_OUT-1:0] a_q;

  // ========================================================================
  // Host writes
  // ========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < `GAT_FEAT_IN; r++) begin
        w_q[r] <= '0;
      end
      a_q <= '0;
    end else begin
      if (wgt_we_i) begin
        w_q[wgt_addr_i[ADDR_W-1:COL_W]][wgt_addr_i[COL_W-1:0]] <= wgt_din_i;
      end
      if (att_we_i) begin
        a_q[att_addr_i] <= att_din_i;
      end
    end
  end

  // ========================================================================
  // Read side
  // ========================================================================
  // Row select follows the column of the incoming sparse entry
  assign w_row_o = w_q[rd_row_i];
  assign a_vec_o = a_q;

endmodule

/* src.f */
+incdir+.
gat_pkg.sv
gat_weight_store.sv
gat_spmm_row.sv
gat_attn_score.sv
gat_top.sv
gat_tb_chk.sv
gat_tb.sv
